// File: verilog/jc_pkg.sv
`default_nettype none

package jc_pkg;

	////////////////////
	// Datapath widths
	////////////////////

	typedef logic [31:0] addr_t;  // Instruction address
	typedef logic [31:0] instr_t; // One fetched instruction word

	// Bimodal counter, 0..1 not taken and 2..3 taken
	typedef logic [1:0] ctr_t;

	////////////////////
	// RISC-V opcodes
	////////////////////

	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011; // All B-type compares
	localparam logic [6:0] OPC_JALR   = 7'b1100111;

	////////////////////
	// Link registers
	////////////////////

	// ra and t0, the two link registers of the calling convention
	localparam logic [4:0] LINK_X1 = 5'd1;
	localparam logic [4:0] LINK_X5 = 5'd5;

endpackage

`default_nettype wire

// File: verilog/predecode_stage.sv
`default_nettype none

module predecode_stage #(
	parameter int FETCH_WIDTH = 4
) (
	input  logic                                clk_i,
	input  logic                                arst_n_i,
	input  logic                                fetch_valid_i,
	input  jc_pkg::addr_t                       fetch_pc_i,
	input  jc_pkg::instr_t [FETCH_WIDTH-1:0]    fetch_instr_i,
	output logic                                pd_valid_o,
	output jc_pkg::addr_t                       pd_pc_o,
	output logic           [FETCH_WIDTH-1:0]    pd_is_jal_o,
	output logic           [FETCH_WIDTH-1:0]    pd_is_branch_o,
	output logic           [FETCH_WIDTH-1:0]    pd_is_jalr_o,
	output logic           [FETCH_WIDTH-1:0]    pd_is_call_o,
	output logic           [FETCH_WIDTH-1:0]    pd_is_return_o
);
	import jc_pkg::*;

	logic [FETCH_WIDTH-1:0] is_jal;
	logic [FETCH_WIDTH-1:0] is_branch;
	logic [FETCH_WIDTH-1:0] is_jalr;
	logic [FETCH_WIDTH-1:0] is_call;
	logic [FETCH_WIDTH-1:0] is_return;

	////////////////////
	// Per-slot decode
	////////////////////

	for (genvar k = 0; k < FETCH_WIDTH; k++) begin : g_slot
		instr_t     instr;
		logic [6:0] opcode;
		logic       rd_link;
		logic       rs1_link;
		logic       rd_zero;

		assign instr    = fetch_instr_i[k];
		assign opcode   = instr[6:0];
		assign rd_link  = (instr[11:7] == LINK_X1) || (instr[11:7] == LINK_X5);
		assign rs1_link = (instr[19:15] == LINK_X1) || (instr[19:15] == LINK_X5);
		assign rd_zero  = (instr[11:7] == 5'd0);

		// Empty bundle decodes to nothing
		assign is_jal[k]    = fetch_valid_i && (opcode == OPC_JAL);
		assign is_branch[k] = fetch_valid_i && (opcode == OPC_BRANCH);
		assign is_jalr[k]   = fetch_valid_i && (opcode == OPC_JALR);

		assign is_call[k]   = (is_jal[k] || is_jalr[k]) && rd_link;
		assign is_return[k] = is_jalr[k] && rs1_link && rd_zero; // jr ra / ret
	end

	////////////////////
	// Stage register
	////////////////////

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pd_valid_o     <= 1'b0;
			pd_is_jal_o    <= '0;
			pd_is_branch_o <= '0;
			pd_is_jalr_o   <= '0;
			pd_is_call_o   <= '0;
			pd_is_return_o <= '0;
		end else begin
			pd_valid_o     <= fetch_valid_i;
			pd_is_jal_o    <= is_jal;
			pd_is_branch_o <= is_branch;
			pd_is_jalr_o   <= is_jalr;
			pd_is_call_o   <= is_call;
			pd_is_return_o <= is_return;
		end
	end

	always_ff @(posedge clk_i) begin
		if (fetch_valid_i) begin
			pd_pc_o <= fetch_pc_i; // Slot PCs rebuilt downstream
		end
	end

endmodule

`default_nettype wire

// File: verilog/bimodal_predictor.sv
`default_nettype none

module bimodal_predictor #(
	parameter int FETCH_WIDTH = 4,
	parameter int BHT_ENTRIES = 32
) (
	input  logic                   clk_i,
	input  logic                   arst_n_i,
	input  jc_pkg::addr_t          rd_pc_i,
	output logic [FETCH_WIDTH-1:0] rd_taken_o,
	input  logic                   upd_valid_i,
	input  jc_pkg::addr_t          upd_pc_i,
	input  logic                   upd_taken_i
);
	import jc_pkg::*;

	localparam int   IDX_W    = $clog2(BHT_ENTRIES);
	localparam ctr_t CTR_INIT = 2'b01; // Weakly not taken

	ctr_t             table_q [BHT_ENTRIES];
	logic [IDX_W-1:0] upd_idx;
	ctr_t             upd_ctr;
	ctr_t             upd_ctr_next;

	// One read port per slot, index skips the byte offset
	for (genvar k = 0; k < FETCH_WIDTH; k++) begin : g_rd
		addr_t slot_pc;

		assign slot_pc       = rd_pc_i + addr_t'(4 * k);
		assign rd_taken_o[k] = table_q[slot_pc[IDX_W+1:2]][1]; // MSB is the direction
	end

	assign upd_idx = upd_pc_i[IDX_W+1:2];
	assign upd_ctr = table_q[upd_idx];

	// Saturating step
	always_comb begin
		upd_ctr_next = upd_ctr;
		if (upd_taken_i && upd_ctr != 2'b11) begin
			upd_ctr_next = upd_ctr + 2'b01;
		end else if (!upd_taken_i && upd_ctr != 2'b00) begin
			upd_ctr_next = upd_ctr - 2'b01;
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < BHT_ENTRIES; i++) begin
				table_q[i] <= CTR_INIT;
			end
		end else if (upd_valid_i) begin
			table_q[upd_idx] <= upd_ctr_next;
		end
	end

endmodule

`default_nettype wire

// File: verilog/return_stack.sv
`default_nettype none

module return_stack #(
	parameter int RAS_DEPTH = 8
) (
	input  logic                         clk_i,
	input  logic                         arst_n_i,
	input  logic                         push_i,
	input  logic                         pop_i,
	input  jc_pkg::addr_t                push_addr_i,
	input  logic                         restore_en_i,
	input  logic [$clog2(RAS_DEPTH)-1:0] restore_tos_i,
	output jc_pkg::addr_t                top_o,
	output logic [$clog2(RAS_DEPTH)-1:0] tos_o
);
	import jc_pkg::*;

	localparam int PTR_W = $clog2(RAS_DEPTH);

	addr_t            stack_q [RAS_DEPTH];
	logic [PTR_W-1:0] tos_q;
	logic [PTR_W-1:0] tos_d;
	logic [PTR_W-1:0] push_ptr;
	logic             do_push;

	// Power-of-two depth, so plain add and subtract wrap
	assign push_ptr = tos_q + 1'b1;
	assign do_push  = push_i && !restore_en_i; // Restore wins

	assign top_o = stack_q[tos_q];
	assign tos_o = tos_q;

	////////////////////
	// Pointer control
	////////////////////

	always_comb begin
		tos_d = tos_q;
		if (restore_en_i) begin
			tos_d = restore_tos_i; // Checkpoint from a flushed path
		end else if (push_i) begin
			tos_d = push_ptr;
		end else if (pop_i) begin
			tos_d = tos_q - 1'b1;
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			tos_q <= '0;
			for (int i = 0; i < RAS_DEPTH; i++) begin
				stack_q[i] <= '0;
			end
		end else begin
			tos_q <= tos_d;
			if (do_push) begin
				stack_q[push_ptr] <= push_addr_i; // Oldest entry overwritten on wrap
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/select_stage.sv
`default_nettype none

module select_stage #(
	parameter int FETCH_WIDTH = 4,
	parameter int BHT_ENTRIES = 32,
	parameter int RAS_DEPTH   = 8
) (
	input  logic                         clk_i,
	input  logic                         arst_n_i,
	input  logic                         pd_valid_i,
	input  jc_pkg::addr_t                pd_pc_i,
	input  logic [FETCH_WIDTH-1:0]       pd_is_jal_i,
	input  logic [FETCH_WIDTH-1:0]       pd_is_branch_i,
	input  logic [FETCH_WIDTH-1:0]       pd_is_jalr_i,
	input  logic [FETCH_WIDTH-1:0]       pd_is_call_i,
	input  logic [FETCH_WIDTH-1:0]       pd_is_return_i,
	input  logic                         bp_update_valid_i,
	input  jc_pkg::addr_t                bp_update_pc_i,
	input  logic                         bp_update_taken_i,
	input  logic                         ras_restore_en_i,
	input  logic [$clog2(RAS_DEPTH)-1:0] ras_restore_tos_i,
	output logic                         pred_valid_o,
	output logic [FETCH_WIDTH-1:0]       jump_mask_o,
	output logic [FETCH_WIDTH-1:0]       jalr_mask_o,
	output logic                         ret_target_valid_o,
	output jc_pkg::addr_t                ret_target_o,
	output logic [$clog2(RAS_DEPTH)-1:0] ras_tos_o
);
	import jc_pkg::*;

	logic [FETCH_WIDTH-1:0] bp_taken;
	logic [FETCH_WIDTH-1:0] redirect;
	logic [FETCH_WIDTH-1:0] keep;      // Slot at or before the first redirect
	logic [FETCH_WIDTH-1:0] jump_d;
	logic [FETCH_WIDTH-1:0] jalr_d;
	addr_t                  link_addr;
	addr_t                  ras_top;
	logic                   ras_push;
	logic                   ras_pop;

	bimodal_predictor #(
		.FETCH_WIDTH(FETCH_WIDTH),
		.BHT_ENTRIES(BHT_ENTRIES)
	) i_bimodal_predictor (
		.clk_i      (clk_i),
		.arst_n_i   (arst_n_i),
		.rd_pc_i    (pd_pc_i),
		.rd_taken_o (bp_taken),
		.upd_valid_i(bp_update_valid_i),
		.upd_pc_i   (bp_update_pc_i),
		.upd_taken_i(bp_update_taken_i)
	);

	assign redirect = pd_is_jal_i | pd_is_jalr_i | (pd_is_branch_i & bp_taken);

	////////////////////
	// First redirect
	////////////////////

	always_comb begin
		logic seen;
		seen      = 1'b0;
		link_addr = '0;
		for (int k = 0; k < FETCH_WIDTH; k++) begin
			keep[k] = !seen;
			if (redirect[k] && !seen) begin
				link_addr = pd_pc_i + addr_t'(4 * (k + 1)); // Return point of this slot
			end
			seen = seen | redirect[k];
		end
	end

	assign jump_d = (pd_is_jal_i | (pd_is_branch_i & bp_taken)) & keep;
	assign jalr_d = pd_is_jalr_i & keep;

	// Calls and returns redirect, so only the first one survives the mask
	assign ras_push = |(pd_is_call_i & keep);
	assign ras_pop  = |(pd_is_return_i & keep);

	return_stack #(
		.RAS_DEPTH(RAS_DEPTH)
	) i_return_stack (
		.clk_i        (clk_i),
		.arst_n_i     (arst_n_i),
		.push_i       (ras_push),
		.pop_i        (ras_pop),
		.push_addr_i  (link_addr),
		.restore_en_i (ras_restore_en_i),
		.restore_tos_i(ras_restore_tos_i),
		.top_o        (ras_top),
		.tos_o        (ras_tos_o)
	);

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pred_valid_o       <= 1'b0;
			jump_mask_o        <= '0;
			jalr_mask_o        <= '0;
			ret_target_valid_o <= 1'b0;
			ret_target_o       <= '0;
		end else begin
			pred_valid_o       <= pd_valid_i;
			jump_mask_o        <= jump_d;
			jalr_mask_o        <= jalr_d;
			ret_target_valid_o <= ras_pop;
			ret_target_o       <= ras_pop ? ras_top : '0; // Entry before the pop
		end
	end

endmodule

`default_nettype wire

// File: verilog/jump_controller.sv
`default_nettype none

module jump_controller #(
	parameter int FETCH_WIDTH = 4,
	parameter int BHT_ENTRIES = 32,
	parameter int RAS_DEPTH   = 8
) (
	input  logic                                clk_i,
	input  logic                                arst_n_i,
	input  logic                                fetch_valid_i,
	input  jc_pkg::addr_t                       fetch_pc_i,
	input  jc_pkg::instr_t [FETCH_WIDTH-1:0]    fetch_instr_i,
	input  logic                                bp_update_valid_i,
	input  jc_pkg::addr_t                       bp_update_pc_i,
	input  logic                                bp_update_taken_i,
	input  logic                                ras_restore_en_i,
	input  logic           [$clog2(RAS_DEPTH)-1:0] ras_restore_tos_i,
	output logic                                pred_valid_o,
	output logic           [FETCH_WIDTH-1:0]    jump_mask_o,
	output logic           [FETCH_WIDTH-1:0]    jalr_mask_o,
	output logic                                ret_target_valid_o,
	output jc_pkg::addr_t                       ret_target_o,
	output logic           [$clog2(RAS_DEPTH)-1:0] ras_tos_o
);
	import jc_pkg::*;

	// Stage one to stage two
	logic                   pd_valid;
	addr_t                  pd_pc;
	logic [FETCH_WIDTH-1:0] pd_is_jal;
	logic [FETCH_WIDTH-1:0] pd_is_branch;
	logic [FETCH_WIDTH-1:0] pd_is_jalr;
	logic [FETCH_WIDTH-1:0] pd_is_call;
	logic [FETCH_WIDTH-1:0] pd_is_return;

	predecode_stage #(
		.FETCH_WIDTH(FETCH_WIDTH)
	) i_predecode_stage (
		.clk_i         (clk_i),
		.arst_n_i      (arst_n_i),
		.fetch_valid_i (fetch_valid_i),
		.fetch_pc_i    (fetch_pc_i),
		.fetch_instr_i (fetch_instr_i),
		.pd_valid_o    (pd_valid),
		.pd_pc_o       (pd_pc),
		.pd_is_jal_o   (pd_is_jal),
		.pd_is_branch_o(pd_is_branch),
		.pd_is_jalr_o  (pd_is_jalr),
		.pd_is_call_o  (pd_is_call),
		.pd_is_return_o(pd_is_return)
	);

	select_stage #(
		.FETCH_WIDTH(FETCH_WIDTH),
		.BHT_ENTRIES(BHT_ENTRIES),
		.RAS_DEPTH  (RAS_DEPTH)
	) i_select_stage (
		.clk_i             (clk_i),
		.arst_n_i          (arst_n_i),
		.pd_valid_i        (pd_valid),
		.pd_pc_i           (pd_pc),
		.pd_is_jal_i       (pd_is_jal),
		.pd_is_branch_i    (pd_is_branch),
		.pd_is_jalr_i      (pd_is_jalr),
		.pd_is_call_i      (pd_is_call),
		.pd_is_return_i    (pd_is_return),
		.bp_update_valid_i (bp_update_valid_i),
		.bp_update_pc_i    (bp_update_pc_i),
		.bp_update_taken_i (bp_update_taken_i),
		.ras_restore_en_i  (ras_restore_en_i),
		.ras_restore_tos_i (ras_restore_tos_i),
		.pred_valid_o      (pred_valid_o),
		.jump_mask_o       (jump_mask_o),
		.jalr_mask_o       (jalr_mask_o),
		.ret_target_valid_o(ret_target_valid_o),
		.ret_target_o      (ret_target_o),
		.ras_tos_o         (ras_tos_o)
	);

endmodule

`default_nettype wire

// File: tests/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// RISC-V base opcodes
localparam logic [6:0] RV_JAL    = 7'b1101111;
localparam logic [6:0] RV_BRANCH = 7'b1100011;
localparam logic [6:0] RV_JALR   = 7'b1100111;

logic [1:0]       m_ctr [BHT_ENTRIES];  // Bimodal counters
logic [31:0]      m_stack [RAS_DEPTH];
logic [PTR_W-1:0] m_tos;

// Bundle held between the two model stages
logic             m_pd_valid;
logic [31:0]      m_pd_pc;
logic [31:0]      m_pd_instr [FETCH_WIDTH];

// Outputs expected after the current edge
logic                   exp_valid;
logic [FETCH_WIDTH-1:0] exp_jump;
logic [FETCH_WIDTH-1:0] exp_jalr;
logic                   exp_ret_valid;
logic [31:0]            exp_ret_target;
logic [PTR_W-1:0]       exp_tos;

function automatic int ctr_index(input logic [31:0] pc);
	return int'(pc >> 2) % BHT_ENTRIES; // Word index modulo table size
endfunction

function automatic logic is_link(input logic [4:0] r);
	return (r == 5'd1) || (r == 5'd5);
endfunction

task automatic model_reset();
	for (int i = 0; i < BHT_ENTRIES; i++) begin
		m_ctr[i] = 2'd1;
	end
	for (int i = 0; i < RAS_DEPTH; i++) begin
		m_stack[i] = '0;
	end
	m_tos      = '0;
	m_pd_valid = 1'b0;
	m_pd_pc    = '0;
endtask

// One rising edge: stage two decision, then state updates, then stage one capture
task automatic model_step();
	logic [6:0]  opc;
	logic [4:0]  rd;
	logic [31:0] slot_pc;
	logic [31:0] link;
	logic        taken_br;
	logic        push;
	logic        pop;
	logic        found;
	{push, pop, found} = 3'b000;
	link     = '0;
	exp_jump = '0;
	exp_jalr = '0;
	for (int k = 0; k < FETCH_WIDTH; k++) begin
		opc      = m_pd_instr[k][6:0];
		rd       = m_pd_instr[k][11:7];
		slot_pc  = m_pd_pc + 32'(4 * k);
		taken_br = (opc == RV_BRANCH) && (m_ctr[ctr_index(slot_pc)] >= 2'd2);
		if (m_pd_valid && !found && (opc == RV_JAL || opc == RV_JALR || taken_br)) begin
			found       = 1'b1;
			exp_jump[k] = (opc != RV_JALR);
			exp_jalr[k] = (opc == RV_JALR);
			push        = (opc != RV_BRANCH) && is_link(rd);
			pop         = (opc == RV_JALR) && is_link(m_pd_instr[k][19:15]) && (rd == 5'd0);
			link        = slot_pc + 32'd4;
		end
	end
	exp_valid      = m_pd_valid;
	exp_ret_valid  = pop;
	exp_ret_target = pop ? m_stack[m_tos] : 32'h0; // Read before the pop
	if (bp_update_valid) begin
		if (bp_update_taken && m_ctr[ctr_index(bp_update_pc)] != 2'd3) begin
			m_ctr[ctr_index(bp_update_pc)]++;
		end else if (!bp_update_taken && m_ctr[ctr_index(bp_update_pc)] != 2'd0) begin
			m_ctr[ctr_index(bp_update_pc)]--;
		end
	end
	if (ras_restore_en) begin
		m_tos = ras_restore_tos;
	end else if (push) begin
		m_tos          = m_tos + PTR_W'(1);
		m_stack[m_tos] = link;
	end else if (pop) begin
		m_tos = m_tos - PTR_W'(1);
	end
	exp_tos    = m_tos;
	m_pd_valid = fetch_valid;
	m_pd_pc    = fetch_pc;
	for (int k = 0; k < FETCH_WIDTH; k++) begin
		m_pd_instr[k] = fetch_instr[k];
	end
endtask

`endif

// File: tests/tb_jump_controller.sv
`default_nettype none

module tb_jump_controller;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int FETCH_WIDTH  = 4;
	localparam int BHT_ENTRIES  = 32;
	localparam int RAS_DEPTH    = 8;
	localparam int PTR_W        = $clog2(RAS_DEPTH);
	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 4;
	localparam int NUM_BUNDLES  = 2000;
	localparam int WATCHDOG_NS  = (NUM_BUNDLES + 10) * CLK_PERIOD;

	logic                         clk;
	logic                         arst_n;
	logic                         fetch_valid;
	logic [31:0]                  fetch_pc;
	logic [FETCH_WIDTH-1:0][31:0] fetch_instr;
	logic                         bp_update_valid;
	logic [31:0]                  bp_update_pc;
	logic                         bp_update_taken;
	logic                         ras_restore_en;
	logic [PTR_W-1:0]             ras_restore_tos;
	logic                         pred_valid;
	logic [FETCH_WIDTH-1:0]       jump_mask;
	logic [FETCH_WIDTH-1:0]       jalr_mask;
	logic                         ret_target_valid;
	logic [31:0]                  ret_target;
	logic [PTR_W-1:0]             ras_tos;
	integer                       seed;

	`include "tb_model.svh"

	jump_controller #(
		.FETCH_WIDTH(FETCH_WIDTH),
		.BHT_ENTRIES(BHT_ENTRIES),
		.RAS_DEPTH  (RAS_DEPTH)
	) i_jump_controller (
		.clk_i             (clk),
		.arst_n_i          (arst_n),
		.fetch_valid_i     (fetch_valid),
		.fetch_pc_i        (fetch_pc),
		.fetch_instr_i     (fetch_instr),
		.bp_update_valid_i (bp_update_valid),
		.bp_update_pc_i    (bp_update_pc),
		.bp_update_taken_i (bp_update_taken),
		.ras_restore_en_i  (ras_restore_en),
		.ras_restore_tos_i (ras_restore_tos),
		.pred_valid_o      (pred_valid),
		.jump_mask_o       (jump_mask),
		.jalr_mask_o       (jalr_mask),
		.ret_target_valid_o(ret_target_valid),
		.ret_target_o      (ret_target),
		.ras_tos_o         (ras_tos)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////
	// Stimulus
	////////////////////

	function automatic int rand_below(input int n);
		int r;
		r = $random(seed);
		return (r & 32'h7fff_ffff) % n;
	endfunction

	function automatic logic [4:0] pick_reg();
		case (rand_below(3))
			0:       return 5'd0;
			1:       return 5'd1;
			default: return 5'd5;
		endcase
	endfunction

	// Phase 2 leans on calls, phase 3 on returns
	function automatic logic [31:0] make_instr(input int phase);
		logic [31:0] w;
		int          pick;
		w    = $random(seed);
		pick = rand_below(20);
		if (pick < 5) w[6:0] = RV_JAL;
		else if (pick < 11) w[6:0] = RV_BRANCH;
		else if (pick < 16) w[6:0] = RV_JALR;
		else w[6:0] = (pick < 18) ? 7'b0010011 : 7'b0110011; // ALU ops
		if (rand_below(10) < 7) w[11:7] = pick_reg();
		if (rand_below(10) < 7) w[19:15] = pick_reg();
		if (phase == 2 && rand_below(3) == 0) begin
			w[6:0]  = RV_JAL;
			w[11:7] = 5'd1;
		end
		if (phase == 3 && rand_below(3) == 0) begin
			w[6:0]   = RV_JALR;
			w[11:7]  = 5'd0;
			w[19:15] = pick_reg() | 5'd1; // x1 or x5
		end
		return w;
	endfunction

	task automatic drive_bundle(input int n);
		int phase;
		phase       = (n / 250) % 4;
		fetch_valid = rand_below(8) != 0;
		fetch_pc    = 32'h1000 + 32'(4 * rand_below(16));
		for (int k = 0; k < FETCH_WIDTH; k++) begin
			fetch_instr[k] = make_instr(phase);
		end
		bp_update_valid = rand_below(2) == 1;
		bp_update_pc    = 32'h1000 + 32'(4 * rand_below(8)); // Few PCs so counters saturate
		case (phase)
			0:       bp_update_taken = rand_below(8) != 0;
			1:       bp_update_taken = rand_below(8) == 0;
			default: bp_update_taken = rand_below(2) == 1;
		endcase
		ras_restore_en  = rand_below(20) == 0;
		ras_restore_tos = PTR_W'(rand_below(RAS_DEPTH));
	endtask

	////////////////////
	// Checking
	////////////////////

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
				   input string what);
		if (actual !== expected) begin
			$display("error %0d ns: %s is %h, expected %h", $time, what, actual, expected);
			$display("Checks failed");
			$fatal(1, "Output mismatch on %s", what);
		end
	endtask

	task automatic compare_outputs();
		check_value(32'(pred_valid), 32'(exp_valid), "pred_valid_o");
		check_value(32'(jump_mask), 32'(exp_jump), "jump_mask_o");
		check_value(32'(jalr_mask), 32'(exp_jalr), "jalr_mask_o");
		check_value(32'(ret_target_valid), 32'(exp_ret_valid), "ret_target_valid_o");
		check_value(ret_target, exp_ret_target, "ret_target_o");
		check_value(32'(ras_tos), 32'(exp_tos), "ras_tos_o");
	endtask

	initial begin
		seed            = 39775;
		clk             = 1'b0;
		arst_n          = 1'b0;
		fetch_valid     = 1'b0;
		fetch_pc        = '0;
		fetch_instr     = '0;
		bp_update_valid = 1'b0;
		bp_update_pc    = '0;
		bp_update_taken = 1'b0;
		ras_restore_en  = 1'b0;
		ras_restore_tos = '0;
		$display("Seed: %0d", seed);
		model_reset();
		repeat (RESET_CYCLES) @(posedge clk);
		#2 arst_n = 1'b1;
		for (int n = 0; n < NUM_BUNDLES + 2; n++) begin
			@(posedge clk);
			#1;
			model_step();
			compare_outputs();
			#1;
			if (n < NUM_BUNDLES) begin
				drive_bundle(n);
			end else begin
				fetch_valid     = 1'b0; // Drain the pipeline
				bp_update_valid = 1'b0;
				ras_restore_en  = 1'b0;
			end
		end
		$display("All checks passed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Checks failed");
		$fatal(1, "Timeout, the test did not finish within %0d ns", WATCHDOG_NS);
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+tests
verilog/jc_pkg.sv
verilog/predecode_stage.sv
verilog/bimodal_predictor.sv
verilog/return_stack.sv
verilog/select_stage.sv
verilog/jump_controller.sv
tests/tb_jump_controller.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_jump_controller
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SEED_LOG  ?= seed.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  := All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f build.f --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep "Seed:" $(LOG) > $(SEED_LOG) || true
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG) $(SEED_LOG)
